/* gpu_wb_params.svh */
`ifndef GPU_WB_PARAMS_SVH
`define GPU_WB_PARAMS_SVH

// Result shape
`define WB_VEC_SIZE     4
`define WB_DATA_WIDTH   32
`define WB_TAG_WIDTH    8
`define WB_ADDR_WIDTH   32

// Vector register file
`define WB_NUM_REGS     16

// Buffer sizes
`define WB_RESULT_DEPTH 8
`define WB_STORE_DEPTH  4

`endif

/* gpu_wb_pkg.sv */
`include "gpu_wb_params.svh"

package gpu_wb_pkg;

    // All lanes of one result, lane 0 in the low bits
    typedef logic [`WB_VEC_SIZE-1:0][`WB_DATA_WIDTH-1:0] vec_data_t;

    typedef logic [`WB_TAG_WIDTH-1:0] tag_t;

    typedef logic [$clog2(`WB_NUM_REGS)-1:0] reg_idx_t;

    typedef logic [`WB_ADDR_WIDTH-1:0] addr_t;

    // One finished result as held in the result buffer
    typedef struct packed {
        vec_data_t data;
        tag_t      tag;
        reg_idx_t  dest;
        logic      is_vector;
        logic      write_mem;
        addr_t     addr;
    } wb_entry_t;

    // One pending memory write
    typedef struct packed {
        addr_t     addr;
        vec_data_t data;
    } store_entry_t;

endpackage

/* wb_fifo.sv */
`timescale 1ns/1ps

module wb_fifo
    import gpu_wb_pkg::*;
#(
    parameter int  DEPTH = 8,
    parameter type T     = wb_entry_t
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_push,
    input  T                             i_push_data,
    input  logic                         i_pop,
    output T                             o_head,
    output logic                         o_empty,
    output logic                         o_full,
    output logic [$clog2(DEPTH+1)-1:0]   o_count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Payload storage
    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end

            // Push and pop together leave the count unchanged
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign o_head  = mem[rd_ptr];
    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_count = count;

endmodule

/* reg_scoreboard.sv */
`timescale 1ns/1ps

`include "gpu_wb_params.svh"

module reg_scoreboard
    import gpu_wb_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    // Issue side
    input  logic     i_issue_valid,
    input  reg_idx_t i_issue_dest,
    input  tag_t     i_issue_tag,

    // Check of the result at the buffer head
    input  reg_idx_t i_chk_dest,
    input  tag_t     i_chk_tag,
    output logic     o_stale,
    output logic     o_match,
    input  logic     i_clear,

    // Read port
    input  reg_idx_t i_rd_addr,
    output logic     o_rd_pending
);

    logic [`WB_NUM_REGS-1:0] pending;
    tag_t                    newest_tag [`WB_NUM_REGS];
    logic                    issue_hits_chk;

    // A fresh issue to the checked register keeps it pending
    assign issue_hits_chk = i_issue_valid && (i_issue_dest == i_chk_dest);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
            for (int i = 0; i < `WB_NUM_REGS; i++) begin
                newest_tag[i] <= '0;
            end
        end else begin
            if (i_clear && !issue_hits_chk) begin
                pending[i_chk_dest] <= 1'b0;
            end
            if (i_issue_valid) begin
                pending[i_issue_dest]    <= 1'b1;
                newest_tag[i_issue_dest] <= i_issue_tag;
            end
        end
    end

    // Stale means a newer write to the same register is in flight
    assign o_stale = pending[i_chk_dest] && (newest_tag[i_chk_dest] != i_chk_tag);
    assign o_match = pending[i_chk_dest] && (newest_tag[i_chk_dest] == i_chk_tag);

    assign o_rd_pending = pending[i_rd_addr];

endmodule

/* vec_reg_file.sv */
`timescale 1ns/1ps

`include "gpu_wb_params.svh"

module vec_reg_file
    import gpu_wb_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    // Write port, one enable per lane
    input  logic                    i_we,
    input  reg_idx_t                i_waddr,
    input  logic [`WB_VEC_SIZE-1:0] i_lane_mask,
    input  vec_data_t               i_wdata,

    // Combinational read port
    input  reg_idx_t                i_raddr,
    output vec_data_t               o_rdata
);

    vec_data_t regs [`WB_NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `WB_NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (i_we) begin
            // Masked lanes keep their old value
            for (int l = 0; l < `WB_VEC_SIZE; l++) begin
                if (i_lane_mask[l]) begin
                    regs[i_waddr][l] <= i_wdata[l];
                end
            end
        end
    end

    assign o_rdata = regs[i_raddr];

endmodule

/* wb_ctrl.sv */
`timescale 1ns/1ps

`include "gpu_wb_params.svh"

module wb_ctrl
    import gpu_wb_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    // Result buffer head
    input  wb_entry_t               i_head,
    input  logic                    i_buf_empty,
    output logic                    o_buf_pop,

    // Scoreboard
    input  logic                    i_stale,
    input  logic                    i_match,
    output logic                    o_sb_clear,

    // Register file write port
    output logic                    o_rf_we,
    output reg_idx_t                o_rf_addr,
    output logic [`WB_VEC_SIZE-1:0] o_rf_mask,
    output vec_data_t               o_rf_data,

    // Store queue
    input  logic                    i_sq_full,
    output logic                    o_sq_push,
    output store_entry_t            o_sq_entry,

    // Status
    input  logic                    i_result_valid,
    input  logic                    i_buf_full,
    output logic                    o_buffer_overflow,
    output logic [7:0]              o_stale_count
);

    logic retire;
    logic reg_retire;
    logic drop;

    // A store head waits while the store queue has no room
    assign retire     = !i_buf_empty && (!i_head.write_mem || !i_sq_full);
    assign reg_retire = retire && !i_head.write_mem;
    assign drop       = reg_retire && i_stale;

    assign o_buf_pop = retire;

    // Store path
    assign o_sq_push       = retire && i_head.write_mem;
    assign o_sq_entry.addr = i_head.addr;
    assign o_sq_entry.data = i_head.data;

    // Register path, scalar results touch lane 0 only
    assign o_rf_we   = reg_retire && !i_stale;
    assign o_rf_addr = i_head.dest;
    assign o_rf_mask = i_head.is_vector ? '1 : `WB_VEC_SIZE'(1);
    assign o_rf_data = i_head.data;

    // Only the newest write for a register releases its pending bit
    assign o_sb_clear = reg_retire && i_match;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_buffer_overflow <= 1'b0;
            o_stale_count     <= '0;
        end else begin
            // Sticky until reset
            if (i_result_valid && i_buf_full) begin
                o_buffer_overflow <= 1'b1;
            end
            if (drop) begin
                o_stale_count <= o_stale_count + 8'd1;
            end
        end
    end

endmodule

/* gpu_wb_top.sv */
`timescale 1ns/1ps

`include "gpu_wb_params.svh"

module gpu_wb_top
    import gpu_wb_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_n,

    // Results from the execution units
    input  logic                                 i_result_valid,
    input  vec_data_t                            i_result_data,
    input  tag_t                                 i_result_tag,
    input  reg_idx_t                             i_result_dest,
    input  logic                                 i_result_is_vector,
    input  logic                                 i_result_write_mem,
    input  addr_t                                i_result_addr,

    // Issue notifications
    input  logic                                 i_issue_valid,
    input  reg_idx_t                             i_issue_dest,
    input  tag_t                                 i_issue_tag,

    // Memory write port
    output logic                                 o_mem_we,
    output addr_t                                o_mem_addr,
    output vec_data_t                            o_mem_data,
    input  logic                                 i_mem_busy,

    // Register read port
    input  reg_idx_t                             i_rd_addr,
    output vec_data_t                            o_rd_data,
    output logic                                 o_rd_pending,

    // Status
    output logic                                 o_buffer_full,
    output logic [$clog2(`WB_RESULT_DEPTH+1)-1:0] o_buffer_count,
    output logic                                 o_buffer_overflow,
    output logic [7:0]                           o_stale_count
);

    wb_entry_t               in_entry;
    logic                    res_push;
    wb_entry_t               head;
    logic                    buf_empty;
    logic                    buf_pop;

    logic                    stale;
    logic                    match;
    logic                    sb_clear;

    logic                    rf_we;
    reg_idx_t                rf_addr;
    logic [`WB_VEC_SIZE-1:0] rf_mask;
    vec_data_t               rf_data;

    logic                    sq_push;
    store_entry_t            sq_entry;
    store_entry_t            sq_head;
    logic                    sq_empty;
    logic                    sq_full;
    logic                    sq_pop;

    assign in_entry.data      = i_result_data;
    assign in_entry.tag       = i_result_tag;
    assign in_entry.dest      = i_result_dest;
    assign in_entry.is_vector = i_result_is_vector;
    assign in_entry.write_mem = i_result_write_mem;
    assign in_entry.addr      = i_result_addr;

    // Results offered while full are lost
    assign res_push = i_result_valid && !o_buffer_full;

    wb_fifo #(.DEPTH(`WB_RESULT_DEPTH), .T(wb_entry_t)) result_fifo_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_push      (res_push),
        .i_push_data (in_entry),
        .i_pop       (buf_pop),
        .o_head      (head),
        .o_empty     (buf_empty),
        .o_full      (o_buffer_full),
        .o_count     (o_buffer_count)
    );

    reg_scoreboard scoreboard_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_issue_valid (i_issue_valid),
        .i_issue_dest  (i_issue_dest),
        .i_issue_tag   (i_issue_tag),
        .i_chk_dest    (head.dest),
        .i_chk_tag     (head.tag),
        .o_stale       (stale),
        .o_match       (match),
        .i_clear       (sb_clear),
        .i_rd_addr     (i_rd_addr),
        .o_rd_pending  (o_rd_pending)
    );

    vec_reg_file reg_file_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_we        (rf_we),
        .i_waddr     (rf_addr),
        .i_lane_mask (rf_mask),
        .i_wdata     (rf_data),
        .i_raddr     (i_rd_addr),
        .o_rdata     (o_rd_data)
    );

    wb_ctrl ctrl_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .i_head            (head),
        .i_buf_empty       (buf_empty),
        .o_buf_pop         (buf_pop),
        .i_stale           (stale),
        .i_match           (match),
        .o_sb_clear        (sb_clear),
        .o_rf_we           (rf_we),
        .o_rf_addr         (rf_addr),
        .o_rf_mask         (rf_mask),
        .o_rf_data         (rf_data),
        .i_sq_full         (sq_full),
        .o_sq_push         (sq_push),
        .o_sq_entry        (sq_entry),
        .i_result_valid    (i_result_valid),
        .i_buf_full        (o_buffer_full),
        .o_buffer_overflow (o_buffer_overflow),
        .o_stale_count     (o_stale_count)
    );

    wb_fifo #(.DEPTH(`WB_STORE_DEPTH), .T(store_entry_t)) store_fifo_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_push      (sq_push),
        .i_push_data (sq_entry),
        .i_pop       (sq_pop),
        .o_head      (sq_head),
        .o_empty     (sq_empty),
        .o_full      (sq_full),
        .o_count     ()
    );

    // Store queue head goes out whenever memory is not busy
    assign o_mem_we   = !sq_empty;
    assign o_mem_addr = sq_head.addr;
    assign o_mem_data = sq_head.data;
    assign sq_pop     = o_mem_we && !i_mem_busy;

endmodule

/* tb_gpu_wb.sv */
`timescale 1ns/1ps

`include "gpu_wb_params.svh"

module tb_gpu_wb
    import gpu_wb_pkg::*;
();

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 400;

    logic                                  clk;
    logic                                  rst_n;
    logic                                  i_result_valid;
    vec_data_t                             i_result_data;
    tag_t                                  i_result_tag;
    reg_idx_t                              i_result_dest;
    logic                                  i_result_is_vector;
    logic                                  i_result_write_mem;
    addr_t                                 i_result_addr;
    logic                                  i_issue_valid;
    reg_idx_t                              i_issue_dest;
    tag_t                                  i_issue_tag;
    logic                                  o_mem_we;
    addr_t                                 o_mem_addr;
    vec_data_t                             o_mem_data;
    logic                                  i_mem_busy;
    reg_idx_t                              i_rd_addr;
    vec_data_t                             o_rd_data;
    logic                                  o_rd_pending;
    logic                                  o_buffer_full;
    logic [$clog2(`WB_RESULT_DEPTH+1)-1:0] o_buffer_count;
    logic                                  o_buffer_overflow;
    logic [7:0]                            o_stale_count;

    // Reference model updated in acceptance order
    vec_data_t    exp_regs [`WB_NUM_REGS];
    logic         exp_pend [`WB_NUM_REGS];
    tag_t         exp_tag  [`WB_NUM_REGS];
    logic [7:0]   exp_stale;
    store_entry_t exp_stores [$];
    int           store_idx = 0;
    tag_t         next_tag;

    gpu_wb_top dut_i (.*);

    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_vec(input string name, input vec_data_t got, input vec_data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_store(input string name, input store_entry_t got,
                               input store_entry_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    function automatic vec_data_t random_vec();
        vec_data_t v;
        for (int l = 0; l < `WB_VEC_SIZE; l++) begin
            v[l] = $urandom;
        end
        return v;
    endfunction

    // Writeback rules applied to one accepted result
    function automatic void model_accept(input bit is_store, input reg_idx_t dest, input tag_t tag,
                                         input bit is_vec, input addr_t addr, input vec_data_t data);
        store_entry_t st;
        if (is_store) begin
            st.addr = addr;
            st.data = data;
            exp_stores.push_back(st);
        end else if (exp_pend[dest] && exp_tag[dest] != tag) begin
            exp_stale = exp_stale + 8'd1;
        end else begin
            if (is_vec) begin
                exp_regs[dest] = data;
            end else begin
                exp_regs[dest][0] = data[0];
            end
            exp_pend[dest] = 1'b0;
        end
    endfunction

    task automatic issue_write(input reg_idx_t dest, input tag_t tag);
        i_issue_valid  = 1'b1;
        i_issue_dest   = dest;
        i_issue_tag    = tag;
        exp_pend[dest] = 1'b1;
        exp_tag[dest]  = tag;
        @(negedge clk);
        i_issue_valid = 1'b0;
    endtask

    task automatic send_result(input bit is_store, input reg_idx_t dest, input tag_t tag,
                               input bit is_vec, input addr_t addr, input vec_data_t data,
                               output bit accepted);
        // Full cannot change before the next edge
        accepted           = !o_buffer_full;
        i_result_valid     = 1'b1;
        i_result_write_mem = is_store;
        i_result_dest      = dest;
        i_result_tag       = tag;
        i_result_is_vector = is_vec;
        i_result_addr      = addr;
        i_result_data      = data;
        if (accepted) begin
            model_accept(is_store, dest, tag, is_vec, addr, data);
        end
        @(negedge clk);
        i_result_valid = 1'b0;
    endtask

    // Wait until the result buffer and the store queue are both empty
    task automatic drain(input bit toggle_busy);
        while (o_buffer_count != '0 || o_mem_we) begin
            i_mem_busy = toggle_busy ? 1'($urandom_range(0, 1)) : 1'b0;
            @(negedge clk);
        end
        i_mem_busy = 1'b0;
    endtask

    task automatic check_reg(input int r);
        i_rd_addr = reg_idx_t'(r);
        @(posedge clk);
        check_vec($sformatf("o_rd_data[r%0d]", r), o_rd_data, exp_regs[r]);
        check_bit($sformatf("o_rd_pending[r%0d]", r), o_rd_pending, exp_pend[r]);
        @(negedge clk);
    endtask

    task automatic check_stores_done();
        if (store_idx != exp_stores.size()) begin
            abort_run($sformatf("Only %0d of %0d expected stores left on the memory port",
                                store_idx, exp_stores.size()));
        end
    endtask

    task automatic test_reset_state();
        check_bit("o_mem_we", o_mem_we, 1'b0);
        check_bit("o_buffer_full", o_buffer_full, 1'b0);
        check_bit("o_buffer_overflow", o_buffer_overflow, 1'b0);
        check_count("o_buffer_count", 8'(o_buffer_count), 8'd0);
        check_count("o_stale_count", o_stale_count, 8'd0);
        for (int r = 0; r < `WB_NUM_REGS; r++) begin
            check_reg(r);
        end
    endtask

    task automatic test_scalar_vector();
        bit acc;
        send_result(1'b0, 4'd3, 8'd0, 1'b1, '0, random_vec(), acc);
        check_bit("o_buffer_full", !acc, 1'b0);
        drain(1'b0);
        check_reg(3);
        // Scalar result touches lane 0 only
        send_result(1'b0, 4'd3, 8'd0, 1'b0, '0, random_vec(), acc);
        check_bit("o_buffer_full", !acc, 1'b0);
        drain(1'b0);
        check_reg(3);
    endtask

    task automatic test_stale_drop();
        bit acc;
        issue_write(4'd5, 8'd1);
        issue_write(4'd5, 8'd2);
        send_result(1'b0, 4'd5, 8'd1, 1'b1, '0, random_vec(), acc);
        check_bit("o_buffer_full", !acc, 1'b0);
        drain(1'b0);
        check_reg(5);
        check_count("o_stale_count", o_stale_count, exp_stale);
        send_result(1'b0, 4'd5, 8'd2, 1'b1, '0, random_vec(), acc);
        check_bit("o_buffer_full", !acc, 1'b0);
        drain(1'b0);
        check_reg(5);
        check_count("o_stale_count", o_stale_count, exp_stale);
    endtask

    task automatic test_store_order();
        bit acc;
        for (int i = 0; i < 8; i++) begin
            i_mem_busy = 1'($urandom_range(0, 1));
            send_result(1'b1, '0, '0, 1'b1, addr_t'(32'h1000 + 16 * i), random_vec(), acc);
            check_bit("o_buffer_full", !acc, 1'b0);
        end
        drain(1'b1);
        check_stores_done();
    endtask

    task automatic test_backpressure();
        int n_acc;
        bit acc;
        n_acc      = 0;
        check_bit("o_buffer_overflow", o_buffer_overflow, 1'b0);
        i_mem_busy = 1'b1;
        for (int i = 0; i < 14; i++) begin
            send_result(1'b1, '0, '0, 1'b1, addr_t'(32'h2000 + 16 * i), random_vec(), acc);
            if (acc) begin
                n_acc++;
            end
        end
        check_count("accepted stores", 8'(n_acc), 8'(`WB_RESULT_DEPTH + `WB_STORE_DEPTH));
        check_bit("o_buffer_full", o_buffer_full, 1'b1);
        check_bit("o_buffer_overflow", o_buffer_overflow, 1'b1);
        drain(1'b0);
        check_bit("o_buffer_overflow", o_buffer_overflow, 1'b1);
        check_stores_done();
    endtask

    task automatic test_random_mix();
        bit       is_store;
        bit       acc;
        reg_idx_t r;
        tag_t     t;
        for (int n = 0; n < 60; n++) begin
            is_store = ($urandom_range(0, 2) == 0);
            r        = reg_idx_t'($urandom_range(0, `WB_NUM_REGS - 1));
            if (!is_store && $urandom_range(0, 1) == 1) begin
                // Older results retire before the newest tag moves on
                drain(1'b0);
                issue_write(r, next_tag);
                next_tag = next_tag + 8'd1;
            end
            t = ($urandom_range(0, 1) == 1) ? exp_tag[r] : tag_t'($urandom);
            i_mem_busy = 1'($urandom_range(0, 1));
            send_result(is_store, r, t, 1'($urandom_range(0, 1)), addr_t'($urandom),
                        random_vec(), acc);
        end
        drain(1'b0);
        for (int i = 0; i < `WB_NUM_REGS; i++) begin
            check_reg(i);
        end
        check_count("o_stale_count", o_stale_count, exp_stale);
        check_stores_done();
    endtask

    // Each store that leaves must be the next one expected
    always @(posedge clk) begin : mem_monitor
        store_entry_t got;
        got.addr = o_mem_addr;
        got.data = o_mem_data;
        if (rst_n && o_mem_we && !i_mem_busy) begin
            if (store_idx >= exp_stores.size()) begin
                abort_run($sformatf("Unexpected store to address %h at %0t", got.addr, $time));
            end else begin
                check_store("o_mem_addr/o_mem_data", got, exp_stores[store_idx]);
                store_idx++;
            end
        end
    end

    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        abort_run("Timeout: the tests did not finish within the cycle budget");
    end

    initial begin
        void'($urandom(84));
        clk                = 1'b0;
        rst_n              = 1'b0;
        i_result_valid     = 1'b0;
        i_result_data      = '0;
        i_result_tag       = '0;
        i_result_dest      = '0;
        i_result_is_vector = 1'b0;
        i_result_write_mem = 1'b0;
        i_result_addr      = '0;
        i_issue_valid      = 1'b0;
        i_issue_dest       = '0;
        i_issue_tag        = '0;
        i_mem_busy         = 1'b0;
        i_rd_addr          = '0;
        next_tag           = 8'h10;
        exp_stale          = '0;
        for (int r = 0; r < `WB_NUM_REGS; r++) begin
            exp_regs[r] = '0;
            exp_pend[r] = 1'b0;
            exp_tag[r]  = '0;
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        test_scalar_vector();
        test_stale_drop();
        test_store_order();
        test_backpressure();
        test_random_mix();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* gpu_wb_top.f */
+incdir+.
gpu_wb_pkg.sv
wb_fifo.sv
reg_scoreboard.sv
vec_reg_file.sv
wb_ctrl.sv
gpu_wb_top.sv
tb_gpu_wb.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_gpu_wb \
    -f gpu_wb_top.f -o sim_gpu_wb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_gpu_wb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
